/* hw/jtframe_board.sv */
// Board-side top level: reset, audio DAC, player inputs and VGA colour for one game core
`timescale 1ns/1ps
`default_nettype none

`include "jtframe_cfg.svh"

module jtframe_board
    import jtframe_pkg::*;
#(
    parameter bit SIGNED_SND    = 1'b0,
    parameter bit THREE_BUTTONS = 1'b0
) (
    input  logic                      clk_rgb,
    input  logic                      arst_n,
    // Reset causes
    input  logic                      rst_req,
    input  logic                      dip_flip,
    input  logic                      downloading,
    input  logic                      loop_rst,
    input  logic                      pxl_cen,
    input  logic                      en_mixing,
    input  logic [`JTFRAME_SND_W-1:0] snd,
    input  logic [`JTFRAME_JOY_W-1:0] board_joystick1,
    input  logic [`JTFRAME_JOY_W-1:0] board_joystick2,
    input  game_rgb_t                 game_rgb,
    input  video_ctl_t                video_ctl,
    output logic                      rst,
    output logic                      rst_n,
    output logic                      game_rst,
    output logic                      snd_pwm,    // Same stream for both channels
    output game_ctrl_t                game_ctrl,
    output logic                      game_pause,
    output vga_rgb_t                  vga_rgb,
    output vga_sync_t                 vga_sync
);

    jtframe_reset u_reset (
        .clk_rgb     ( clk_rgb     ),
        .arst_n      ( arst_n      ),
        .rst_req     ( rst_req     ),
        .dip_flip    ( dip_flip    ),
        .downloading ( downloading ),
        .loop_rst    ( loop_rst    ),
        .rst         ( rst         ),
        .rst_n       ( rst_n       ),
        .game_rst    ( game_rst    )
    );

    jtframe_pwm_dac #(
        .SIGNED_SND ( SIGNED_SND )
    ) u_dac (
        .clk_rgb ( clk_rgb ),
        .rst     ( rst     ),
        .snd     ( snd     ),
        .snd_pwm ( snd_pwm )
    );

    // Pause follows the game reset, not the system one
    jtframe_inputs #(
        .THREE_BUTTONS ( THREE_BUTTONS )
    ) u_inputs (
        .clk_rgb         ( clk_rgb         ),
        .game_rst        ( game_rst        ),
        .board_joystick1 ( board_joystick1 ),
        .board_joystick2 ( board_joystick2 ),
        .game_ctrl       ( game_ctrl       ),
        .game_pause      ( game_pause      )
    );

    jtframe_video u_video (
        .clk_rgb   ( clk_rgb   ),
        .rst       ( rst       ),
        .pxl_cen   ( pxl_cen   ),
        .en_mixing ( en_mixing ),
        .game_rgb  ( game_rgb  ),
        .video_ctl ( video_ctl ),
        .vga_rgb   ( vga_rgb   ),
        .vga_sync  ( vga_sync  )
    );

endmodule

`default_nettype wire

/* hw/jtframe_cfg.svh */
// Widths and counts for the board-side framework, included by the package and every RTL block
`ifndef JTFRAME_CFG_SVH
`define JTFRAME_CFG_SVH

// Game colour channel, as produced by the core
`define JTFRAME_COLOR_W 4

// VGA DAC channel on the board
`define JTFRAME_VGA_W 6

`define JTFRAME_SND_W 16   // Sound sample from the core

// Board joystick word, bits 8 and 9 carry coin and start
`define JTFRAME_JOY_W 10

`define JTFRAME_RST_CYCLES 16   // Game reset stretch in clk_rgb cycles

// Flip-flops between arst_n and rst_n
`define JTFRAME_SYNC_STAGES 2

`endif

/* hw/jtframe_inputs.sv */
// Maps board joystick words to the game's active-low controls and keeps the pause toggle
`timescale 1ns/1ps
`default_nettype none

`include "jtframe_cfg.svh"

module jtframe_inputs
    import jtframe_pkg::*;
#(
    parameter bit THREE_BUTTONS = 1'b0
) (
    input  logic                      clk_rgb,
    input  logic                      game_rst,
    input  logic [`JTFRAME_JOY_W-1:0] board_joystick1,   // Active high
    input  logic [`JTFRAME_JOY_W-1:0] board_joystick2,
    output game_ctrl_t                game_ctrl,
    output logic                      game_pause
);

    logic both_start;
    logic last_both;

    // Directions and buttons only, coin and start are split out separately
    function automatic logic [`JTFRAME_JOY_W-1:0] map_joy(
        input logic [`JTFRAME_JOY_W-1:0] board
    );
        logic [`JTFRAME_JOY_W-1:0] joy;
        begin
            joy      = {`JTFRAME_JOY_W{1'b1}};   // All released
            joy[6:0] = ~board[6:0];
            joy[7]   = ~board[7] | THREE_BUTTONS;   // Button 4 unused on 3-button games
            map_joy  = joy;
        end
    endfunction

    always_ff @(posedge clk_rgb) begin
        game_ctrl.joystick1 <= map_joy(board_joystick1);
        game_ctrl.joystick2 <= map_joy(board_joystick2);
        game_ctrl.coin      <= ~{board_joystick2[8], board_joystick1[8]};
        game_ctrl.start     <= ~{board_joystick2[9], board_joystick1[9]};
    end

    assign both_start = board_joystick1[9] & board_joystick2[9];

    // Toggle on the press of both starts, holding them does nothing more
    always_ff @(posedge clk_rgb, posedge game_rst) begin
        if (game_rst) begin
            game_pause <= 1'b0;
            last_both  <= 1'b0;
        end else begin
            last_both <= both_start;
            if (both_start && !last_both) begin
                game_pause <= ~game_pause;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/jtframe_pkg.sv */
// Packed types for colour, sync and player controls, imported by the board blocks
`default_nettype none

`include "jtframe_cfg.svh"

package jtframe_pkg;

    // Colour as the game core drives it
    typedef struct packed {
        logic [`JTFRAME_COLOR_W-1:0] r;
        logic [`JTFRAME_COLOR_W-1:0] g;
        logic [`JTFRAME_COLOR_W-1:0] b;
    } game_rgb_t;

    // Colour towards the VGA resistor DAC
    typedef struct packed {
        logic [`JTFRAME_VGA_W-1:0] r;
        logic [`JTFRAME_VGA_W-1:0] g;
        logic [`JTFRAME_VGA_W-1:0] b;
    } vga_rgb_t;

    typedef struct packed {
        logic lhbl;     // Horizontal blank, active low
        logic lvbl;     // Vertical blank, active low
        logic hs;
        logic vs;
    } video_ctl_t;

    typedef struct packed {
        logic hs;
        logic vs;
    } vga_sync_t;

    // Everything active low, bit 0 of coin and start is player 1
    typedef struct packed {
        logic [`JTFRAME_JOY_W-1:0] joystick1;
        logic [`JTFRAME_JOY_W-1:0] joystick2;
        logic [1:0]                coin;
        logic [1:0]                start;
    } game_ctrl_t;

endpackage

`default_nettype wire

/* hw/jtframe_pwm_dac.sv */
// One-bit audio output: first-order sigma-delta modulator fed by the game sample
`timescale 1ns/1ps
`default_nettype none

`include "jtframe_cfg.svh"

module jtframe_pwm_dac #(
    parameter bit SIGNED_SND = 1'b0
) (
    input  logic                      clk_rgb,
    input  logic                      rst,
    input  logic [`JTFRAME_SND_W-1:0] snd,
    output logic                      snd_pwm
);

    logic [`JTFRAME_SND_W-1:0] snd_ob;   // Offset binary sample
    logic [`JTFRAME_SND_W-1:0] acc;
    logic [`JTFRAME_SND_W:0]   sum;

    // Two's complement to offset binary is just the sign bit flipped
    always_comb begin
        if (SIGNED_SND) begin
            snd_ob = {~snd[`JTFRAME_SND_W-1], snd[`JTFRAME_SND_W-2:0]};
        end else begin
            snd_ob = snd;
        end
    end

    assign sum = {1'b0, acc} + {1'b0, snd_ob};

    // Carry density follows snd_ob / 2^SND_W
    always_ff @(posedge clk_rgb, posedge rst) begin
        if (rst) begin
            acc     <= '0;
            snd_pwm <= 1'b0;
        end else begin
            acc     <= sum[`JTFRAME_SND_W-1:0];
            snd_pwm <= sum[`JTFRAME_SND_W];   // Carry out
        end
    end

endmodule

`default_nettype wire

/* hw/jtframe_reset.sv */
// Synchronised system reset and stretched game reset, instantiated once by the board top level
`timescale 1ns/1ps
`default_nettype none

`include "jtframe_cfg.svh"

module jtframe_reset (
    input  logic clk_rgb,
    input  logic arst_n,
    input  logic rst_req,      // One-cycle request from the core
    input  logic dip_flip,     // Any change restarts the game
    input  logic downloading,
    input  logic loop_rst,     // SDRAM load in progress
    output logic rst,
    output logic rst_n,
    output logic game_rst
);

    localparam int CNT_W = $clog2(`JTFRAME_RST_CYCLES + 1);

    logic [`JTFRAME_SYNC_STAGES-1:0] sync;
    logic                            last_flip;
    logic                            cause;
    logic [CNT_W-1:0]                cnt;

    // Asynchronous assertion with synchronous release
    always_ff @(posedge clk_rgb, negedge arst_n) begin
        if (!arst_n) begin
            sync <= '0;
        end else begin
            sync <= {sync[`JTFRAME_SYNC_STAGES-2:0], 1'b1};
        end
    end

    assign rst_n = sync[`JTFRAME_SYNC_STAGES-1];

    always_ff @(posedge clk_rgb, negedge arst_n) begin
        if (!arst_n) begin
            rst       <= 1'b1;
            last_flip <= 1'b0;
        end else begin
            rst       <= ~rst_n;   // One cycle behind rst_n
            last_flip <= dip_flip;
        end
    end

    assign cause = rst | rst_req | downloading | loop_rst | (dip_flip != last_flip);

    // Stretch measured from the last cause
    always_ff @(posedge clk_rgb, negedge arst_n) begin
        if (!arst_n) begin
            cnt <= CNT_W'(`JTFRAME_RST_CYCLES);   // Game held from the start
        end else if (cause) begin
            cnt <= CNT_W'(`JTFRAME_RST_CYCLES);
        end else if (cnt != '0) begin
            cnt <= cnt - CNT_W'(1);
        end
    end

    assign game_rst = cnt != '0;

endmodule

`default_nettype wire

/* hw/jtframe_video.sv */
// Game colour to VGA colour: depth expansion, blanking and optional pixel mixing per pxl_cen slot
`timescale 1ns/1ps
`default_nettype none

`include "jtframe_cfg.svh"

module jtframe_video
    import jtframe_pkg::*;
(
    input  logic       clk_rgb,
    input  logic       rst,
    input  logic       pxl_cen,
    input  logic       en_mixing,
    input  game_rgb_t  game_rgb,
    input  video_ctl_t video_ctl,
    output vga_rgb_t   vga_rgb,
    output vga_sync_t  vga_sync
);

    logic     blank;
    vga_rgb_t expanded;
    vga_rgb_t mixed;
    vga_rgb_t prev;     // Last sampled pixel on this line

    // Repeat the top bits so full scale maps to full scale
    function automatic logic [`JTFRAME_VGA_W-1:0] expand(
        input logic [`JTFRAME_COLOR_W-1:0] c
    );
        expand = {c, c[`JTFRAME_COLOR_W-1 -: (`JTFRAME_VGA_W - `JTFRAME_COLOR_W)]};
    endfunction

    // Truncated average of two neighbours
    function automatic logic [`JTFRAME_VGA_W-1:0] mix(
        input logic [`JTFRAME_VGA_W-1:0] a,
        input logic [`JTFRAME_VGA_W-1:0] b
    );
        logic [`JTFRAME_VGA_W:0] s;
        begin
            s   = {1'b0, a} + {1'b0, b};
            mix = s[`JTFRAME_VGA_W:1];
        end
    endfunction

    assign blank = ~video_ctl.lhbl | ~video_ctl.lvbl;

    always_comb begin
        if (blank) begin
            expanded = '0;
        end else begin
            expanded.r = expand(game_rgb.r);
            expanded.g = expand(game_rgb.g);
            expanded.b = expand(game_rgb.b);
        end
        mixed.r = mix(expanded.r, prev.r);
        mixed.g = mix(expanded.g, prev.g);
        mixed.b = mix(expanded.b, prev.b);
    end

    // Blanked pixels stay black even when mixing, prev may still hold the last visible one
    always_ff @(posedge clk_rgb, posedge rst) begin
        if (rst) begin
            vga_rgb  <= '0;
            vga_sync <= '0;
        end else if (pxl_cen) begin
            if (blank) begin
                vga_rgb <= '0;
            end else if (en_mixing) begin
                vga_rgb <= mixed;
            end else begin
                vga_rgb <= expanded;
            end
            vga_sync.hs <= video_ctl.hs;
            vga_sync.vs <= video_ctl.vs;
        end
    end

    // Mixing never crosses the horizontal blank
    always_ff @(posedge clk_rgb, posedge rst) begin
        if (rst) begin
            prev <= '0;
        end else if (!video_ctl.lhbl) begin
            prev <= '0;
        end else if (pxl_cen) begin
            prev <= expanded;
        end
    end

endmodule

`default_nettype wire

/* list.f */
+incdir+hw
hw/jtframe_pkg.sv
hw/jtframe_reset.sv
hw/jtframe_pwm_dac.sv
hw/jtframe_inputs.sv
hw/jtframe_video.sv
hw/jtframe_board.sv
testbench/jtframe_board_asserts.sv
testbench/jtframe_board_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the jtframe_board testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f list.f \
    --top-module jtframe_board_tb \
    -o jtframe_board_sim

./obj_dir/jtframe_board_sim | tee sim.log

if grep -qF "*** TEST PASSED ***" sim.log; then
    echo "Simulation result: pass"
else
    echo "Simulation result: fail"
    exit 1
fi

/* testbench/jtframe_board_asserts.sv */
// Concurrent checks on reset, audio, pause and blanking, bound into every jtframe_board
`timescale 1ns/1ps
`default_nettype none

module jtframe_board_asserts
    import jtframe_pkg::*;
(
    input logic       clk_rgb,
    input logic       rst,
    input logic       game_rst,
    input logic       game_pause,
    input logic       snd_pwm,
    input logic       pxl_cen,
    input video_ctl_t video_ctl,
    input vga_rgb_t   vga_rgb
);

    // System reset always holds the game in reset
    game_rst_covers_rst: assert property (@(posedge clk_rgb) rst |-> game_rst)
        else $error("game_rst low while rst is high");

    blank_is_black: assert property (@(posedge clk_rgb) disable iff (rst)
        pxl_cen && !video_ctl.lhbl |=> vga_rgb == '0)
        else $error("vga_rgb not black after a slot sampled in horizontal blank");

    pause_cleared: assert property (@(posedge clk_rgb) game_rst |-> !game_pause)
        else $error("game_pause high during game reset");

    pwm_known: assert property (@(posedge clk_rgb) disable iff (rst) !$isunknown(snd_pwm))
        else $error("snd_pwm unknown outside reset");   // Catches an uncleared accumulator

endmodule

bind jtframe_board jtframe_board_asserts i_asserts (
    .clk_rgb    ( clk_rgb    ),
    .rst        ( rst        ),
    .game_rst   ( game_rst   ),
    .game_pause ( game_pause ),
    .snd_pwm    ( snd_pwm    ),
    .pxl_cen    ( pxl_cen    ),
    .video_ctl  ( video_ctl  ),
    .vga_rgb    ( vga_rgb    )
);

`default_nettype wire

/* testbench/jtframe_board_tb.sv */
// Drives resets, audio, joysticks and video into jtframe_board and checks against reference models
`timescale 1ns/1ps
`default_nettype none

`include "jtframe_cfg.svh"

module jtframe_board_tb
    import jtframe_pkg::*;
();

    localparam bit THREE_BUTTONS = 1'b0;   // DUT runs with its default
    localparam int RST_CYCLES    = `JTFRAME_RST_CYCLES;
    localparam int PWM_CYCLES    = 4096;

    logic                      clk_rgb;
    logic                      arst_n;
    logic                      rst_req;
    logic                      dip_flip;
    logic                      downloading;
    logic                      loop_rst;
    logic                      pxl_cen;
    logic                      en_mixing;
    logic [`JTFRAME_SND_W-1:0] snd;
    logic [`JTFRAME_JOY_W-1:0] board_joystick1;
    logic [`JTFRAME_JOY_W-1:0] board_joystick2;
    game_rgb_t                 game_rgb;
    video_ctl_t                video_ctl;
    logic                      rst;
    logic                      rst_n;
    logic                      game_rst;
    logic                      snd_pwm;
    game_ctrl_t                game_ctrl;
    logic                      game_pause;
    vga_rgb_t                  vga_rgb;
    vga_sync_t                 vga_sync;

    logic [31:0] rng_state = 32'h87ea6927;
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          test_errors_start = 0;

    jtframe_board i_dut (.*);

    initial begin
        clk_rgb = 1'b0;
        forever #5 clk_rgb = ~clk_rgb;
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // High cycles of game_rst for a cause held over cause_len clocks
    function automatic int expected_rst_high(input int cause_len);
        return cause_len - 1 + RST_CYCLES;
    endfunction

    function automatic int expected_ones(input logic [15:0] v, input int n);
        return int'((longint'(v) * longint'(n)) >> 16);   // Lower bound of the allowed pair
    endfunction

    function automatic game_ctrl_t ref_ctrl(
        input logic [`JTFRAME_JOY_W-1:0] j1,
        input logic [`JTFRAME_JOY_W-1:0] j2
    );
        game_ctrl_t c;
        c.joystick1 = {2'b11, ~j1[7:0]};
        c.joystick2 = {2'b11, ~j2[7:0]};
        if (THREE_BUTTONS) begin
            c.joystick1[7] = 1'b1;
            c.joystick2[7] = 1'b1;
        end
        c.coin  = {~j2[8], ~j1[8]};
        c.start = {~j2[9], ~j1[9]};
        return c;
    endfunction

    function automatic vga_rgb_t expand_pixel(input game_rgb_t c, input video_ctl_t ctl);
        vga_rgb_t v;
        v = '0;
        if (ctl.lhbl && ctl.lvbl) begin
            v.r = {c.r, c.r[3:2]};
            v.g = {c.g, c.g[3:2]};
            v.b = {c.b, c.b[3:2]};
        end
        return v;
    endfunction

    function automatic logic [5:0] avg6(input logic [5:0] a, input logic [5:0] b);
        return 6'((int'(a) + int'(b)) / 2);
    endfunction

    function automatic vga_rgb_t ref_pixel(
        input game_rgb_t  c,
        input video_ctl_t ctl,
        input logic       en,
        input vga_rgb_t   prev
    );
        vga_rgb_t e;
        vga_rgb_t m;
        e = expand_pixel(c, ctl);
        if (!en || !ctl.lhbl || !ctl.lvbl) begin
            return e;   // Blanked slots are black in both modes
        end
        m.r = avg6(e.r, prev.r);
        m.g = avg6(e.g, prev.g);
        m.b = avg6(e.b, prev.b);
        return m;
    endfunction

    task automatic step();
        @(posedge clk_rgb);
        #1;
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (expected === actual) else begin
            $display("Error: %s expected %h actual %h at %0t", name, expected, actual, $time);
            errors++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout while waiting for %s at %0t", what, $time);
        errors++;
    endtask

    task automatic finish_test(input string name);
        tests++;
        $display("Test %s done, %0d errors", name, errors - test_errors_start);
        test_errors_start = errors;
    endtask

    // Cause 0 is rst_req, 1 a dip_flip toggle, 2 downloading
    task automatic measure_game_rst(input int which, input int len, output int high);
        int n;
        high = 0;
        n = 0;
        case (which)
            0: rst_req = 1'b1;
            1: dip_flip = ~dip_flip;
            default: downloading = 1'b1;
        endcase
        do begin
            step();
            n++;
            if (game_rst) begin
                high++;
            end
            if (n == len) begin
                rst_req     = 1'b0;
                downloading = 1'b0;
            end
        end while ((game_rst || n < len) && n < len + 4 * RST_CYCLES);
        if (game_rst) begin
            report_timeout("game_rst to fall");
        end
    endtask

    initial begin
        int          n;
        int          high;
        int          len;
        int          ones;
        int          exp_ones;
        logic [31:0] r;
        logic [15:0] v;
        game_ctrl_t  exp_ctrl;
        vga_rgb_t    exp_rgb;
        vga_rgb_t    prev_m;
        vga_sync_t   exp_sync;
        logic        exp_pause;
        string       pix_name;

        arst_n          = 1'b0;
        rst_req         = 1'b0;
        dip_flip        = 1'b0;
        downloading     = 1'b0;
        loop_rst        = 1'b0;
        pxl_cen         = 1'b0;
        en_mixing       = 1'b0;
        snd             = '0;
        board_joystick1 = '0;
        board_joystick2 = '0;
        game_rgb        = '0;
        video_ctl       = '0;
        repeat (4) step();

        // Reset release
        arst_n = 1'b1;
        n = 0;
        do begin
            step();
            n++;
        end while (!rst_n && n < 20);
        checks++;
        assert (rst_n && n <= `JTFRAME_SYNC_STAGES + 1) else begin
            $display("Error: rst_n_release expected within %0d cycles actual %0d",
                     `JTFRAME_SYNC_STAGES + 1, n);
            errors++;
        end
        n = 0;
        while (rst && n < 20) begin
            step();
            n++;
        end
        if (rst) begin
            report_timeout("rst to fall");
        end else begin
            check_value("rst_after_rst_n", 1, n);   // Registered one cycle behind rst_n
        end
        n = 0;
        while (game_rst && n < 4 * RST_CYCLES) begin
            step();
            n++;
        end
        check_value("game_rst_after_rst", RST_CYCLES, n);
        finish_test("reset_release");

        measure_game_rst(0, 1, high);
        check_value("game_rst_rst_req", expected_rst_high(1), high);
        measure_game_rst(1, 1, high);
        check_value("game_rst_dip_flip", expected_rst_high(1), high);
        r = next_rand();
        len = 2 + int'(r[20:16]);
        measure_game_rst(2, len, high);
        check_value("game_rst_downloading", expected_rst_high(len), high);
        finish_test("game_reset_causes");

        for (int k = 0; k < 6; k++) begin
            r = next_rand();
            v = r[31:16];
            snd = v;
            ones = 0;
            for (n = 0; n < PWM_CYCLES; n++) begin
                step();
                if (snd_pwm) begin
                    ones++;
                end
            end
            exp_ones = expected_ones(v, PWM_CYCLES);
            checks++;
            assert (ones >= exp_ones && ones <= exp_ones + 1) else begin
                $display("Error: pwm_density for %h expected %0d or %0d actual %0d",
                         v, exp_ones, exp_ones + 1, ones);
                errors++;
            end
        end
        snd = '0;
        finish_test("pwm_density");

        for (int k = 0; k < 50; k++) begin
            r = next_rand();
            board_joystick1 = r[9:0];
            board_joystick2 = r[25:16];
            exp_ctrl = ref_ctrl(board_joystick1, board_joystick2);
            step();
            check_value("game_ctrl", 32'(exp_ctrl), 32'(game_ctrl));
        end
        board_joystick1 = '0;
        board_joystick2 = '0;
        step();
        finish_test("joystick_map");

        // Start from a cleared pause
        measure_game_rst(0, 1, high);
        check_value("pause_after_reset", 0, 32'(game_pause));
        exp_pause = 1'b0;
        for (int k = 0; k < 3; k++) begin
            board_joystick1[9] = 1'b1;
            board_joystick2[9] = 1'b1;
            exp_pause = ~exp_pause;
            step();
            check_value("pause_press", 32'(exp_pause), 32'(game_pause));
            repeat (5) step();
            check_value("pause_hold", 32'(exp_pause), 32'(game_pause));
            board_joystick1[9] = 1'b0;
            board_joystick2[9] = 1'b0;
            repeat (2) step();
            check_value("pause_release", 32'(exp_pause), 32'(game_pause));
        end
        measure_game_rst(0, 1, high);
        check_value("pause_clear", 0, 32'(game_pause));
        finish_test("pause_toggle");

        exp_rgb  = '0;
        exp_sync = '0;
        prev_m   = '0;
        for (int mode = 0; mode < 2; mode++) begin
            en_mixing = (mode == 1);
            if (en_mixing) begin
                pix_name = "vga_rgb_mixed";
            end else begin
                pix_name = "vga_rgb";
            end
            for (int i = 0; i < 200; i++) begin
                r = next_rand();
                pxl_cen        = i[0];
                game_rgb       = r[11:0];
                video_ctl.lhbl = r[14:12] != 3'd0;
                video_ctl.lvbl = r[18:15] != 4'd0;
                video_ctl.hs   = r[19];
                video_ctl.vs   = r[20];
                if (pxl_cen) begin
                    exp_rgb  = ref_pixel(game_rgb, video_ctl, en_mixing, prev_m);
                    exp_sync = {video_ctl.hs, video_ctl.vs};
                end
                // Previous pixel is cleared on every clock inside the horizontal blank
                if (!video_ctl.lhbl) begin
                    prev_m = '0;
                end else if (pxl_cen) begin
                    prev_m = expand_pixel(game_rgb, video_ctl);
                end
                step();
                check_value(pix_name, 32'(exp_rgb), 32'(vga_rgb));
                check_value("vga_sync", 32'(exp_sync), 32'(vga_sync));
            end
        end
        pxl_cen = 1'b0;
        finish_test("video_path");

        $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
